// ==== design/sdram_map_pkg.sv ====
// Memory map constants shared by the download, client mapping, slot and bank controller blocks
package sdram_map_pkg;

    // Banks and read slots, one slot per bank
    localparam int bank_count = 4;

    // Bank select width
    localparam int ba_w = $clog2(bank_count);

    // Word address width inside one bank
    localparam int bank_aw = 12;

    // SDRAM data width
    localparam int word_w = 16;

    // Download byte address width
    localparam int ioctl_aw = 17;

    // Byte address width of the main and sound CPU clients
    localparam int cpu_aw = 13;

    // Download regions, byte addresses
    // Bank 0 starts at zero
    localparam logic [ioctl_aw-1:0] ba1_start  = 17'h02000;
    localparam logic [ioctl_aw-1:0] ba2_start  = 17'h04000;
    localparam logic [ioctl_aw-1:0] ba3_start  = 17'h06000;
    localparam logic [ioctl_aw-1:0] prom_start = 17'h08000;

    // First byte after the PROM region
    localparam logic [ioctl_aw-1:0] prom_end   = 17'h08300;

    // PROM target select lives in these bits of the PROM offset
    localparam int prom_sel_lsb = 8;

    // Cycles from ack to rdy in the bank controller
    localparam int read_lat = 3;

endpackage

// ==== design/rom_download.sv ====
// ROM download packer that turns the byte stream into bank word writes and PROM strobes
`timescale 1ns/10ps

module rom_download (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                downloading,
    input  logic [sdram_map_pkg::ioctl_aw-1:0]  ioctl_addr,
    input  logic [7:0]                          ioctl_dout,
    input  logic                                ioctl_wr,
    output logic                                prog_we,
    output logic [sdram_map_pkg::ba_w-1:0]      prog_ba,
    output logic [sdram_map_pkg::bank_aw-1:0]   prog_addr,
    output logic [sdram_map_pkg::word_w-1:0]    prog_data,
    output logic [1:0]                          prom_banks,
    output logic                                prom_prior_we
);
    import sdram_map_pkg::*;

    logic                wr_byte;
    logic                in_rom;
    logic                in_prom;
    logic [ba_w-1:0]     bank_sel;
    logic [ioctl_aw-1:0] region_start;
    logic [ioctl_aw-1:0] offset;
    logic [7:0]          low_byte;
    logic                prom_we;
    logic [1:0]          prom_sel;

    assign wr_byte = downloading && ioctl_wr;
    assign in_rom  = ioctl_addr < prom_start;
    assign in_prom = (ioctl_addr >= prom_start) && (ioctl_addr < prom_end);

    // Region decode, one subtractor serves banks and PROMs
    always_comb begin
        if (in_prom) begin
            bank_sel     = '0;
            region_start = prom_start;
        end else if (ioctl_addr >= ba3_start) begin
            bank_sel     = ba_w'(3);
            region_start = ba3_start;
        end else if (ioctl_addr >= ba2_start) begin
            bank_sel     = ba_w'(2);
            region_start = ba2_start;
        end else if (ioctl_addr >= ba1_start) begin
            bank_sel     = ba_w'(1);
            region_start = ba1_start;
        end else begin
            bank_sel     = '0;
            region_start = '0;
        end
    end

    assign offset = ioctl_addr - region_start;

    // Strobes, one cycle after the byte
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= wr_byte && in_rom && ioctl_addr[0];
            prom_we <= wr_byte && in_prom;
        end
    end

    always_ff @(posedge clk) begin
        // Even byte waits for its partner
        if (wr_byte && !ioctl_addr[0]) begin
            low_byte <= ioctl_dout;
        end
        if (wr_byte && in_rom && ioctl_addr[0]) begin
            prog_data <= {ioctl_dout, low_byte};
            prog_ba   <= bank_sel;
            prog_addr <= offset[bank_aw:1];
        end
        if (wr_byte && in_prom) begin
            prom_sel <= offset[prom_sel_lsb+1:prom_sel_lsb];
        end
    end

    // PROM target decode, code 11 selects nothing
    assign prom_banks[0] = prom_we && (prom_sel == 2'b00);
    assign prom_banks[1] = prom_we && (prom_sel == 2'b01);
    assign prom_prior_we = prom_we && (prom_sel == 2'b10);

endmodule

// ==== design/client_map.sv ====
// Client mapper that places the four game clients onto the bank read slots
`timescale 1ns/10ps

module client_map (
    input  logic                               main_cs,
    input  logic [sdram_map_pkg::cpu_aw-1:0]   main_addr,
    input  logic                               snd_cs,
    input  logic [sdram_map_pkg::cpu_aw-1:0]   snd_addr,
    input  logic [sdram_map_pkg::bank_aw-1:0]  gfx_addr,
    input  logic                               obj_cs,
    input  logic [sdram_map_pkg::bank_aw-1:0]  obj_addr,
    input  logic                               lvbl,
    input  logic [sdram_map_pkg::bank_count-1:0][sdram_map_pkg::word_w-1:0] slot_dout,
    input  logic [sdram_map_pkg::bank_count-1:0] slot_ok,
    output logic [sdram_map_pkg::bank_count-1:0] slot_cs,
    output logic [sdram_map_pkg::bank_count-1:0][sdram_map_pkg::bank_aw-1:0] slot_addr,
    output logic [7:0]                         main_data,
    output logic                               main_ok,
    output logic [7:0]                         snd_data,
    output logic                               snd_ok,
    output logic [sdram_map_pkg::word_w-1:0]   gfx_data,
    output logic                               gfx_ok,
    output logic [sdram_map_pkg::word_w-1:0]   obj_data,
    output logic                               obj_ok
);
    import sdram_map_pkg::*;

    // Even byte address is the low half of the word
    function automatic logic [7:0] byte_sel(input logic [word_w-1:0] word, input logic odd);
        return odd ? word[15:8] : word[7:0];
    endfunction

    // Main CPU on bank 0
    assign slot_cs[0]   = main_cs;
    assign slot_addr[0] = main_addr[cpu_aw-1:1];
    assign main_data    = byte_sel(slot_dout[0], main_addr[0]);
    assign main_ok      = slot_ok[0];

    // Sound CPU on bank 1
    assign slot_cs[1]   = snd_cs;
    assign slot_addr[1] = snd_addr[cpu_aw-1:1];
    assign snd_data     = byte_sel(slot_dout[1], snd_addr[0]);
    assign snd_ok       = slot_ok[1];

    // Tiles fetch only during vertical blank
    assign slot_cs[2]   = lvbl;
    assign slot_addr[2] = gfx_addr;
    assign gfx_data     = slot_dout[2];
    assign gfx_ok       = slot_ok[2];

    // Objects on bank 3
    assign slot_cs[3]   = obj_cs;
    assign slot_addr[3] = obj_addr;
    assign obj_data     = slot_dout[3];
    assign obj_ok       = slot_ok[3];

endmodule

// ==== design/rom_slot.sv ====
// Single bank read slot with a one-word cache in front of the SDRAM request port
`timescale 1ns/10ps

module rom_slot (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               flush,
    input  logic                               cs,
    input  logic [sdram_map_pkg::bank_aw-1:0]  addr,
    input  logic                               sdram_ack,
    input  logic                               data_rdy,
    input  logic [sdram_map_pkg::word_w-1:0]   data_read,
    output logic [sdram_map_pkg::word_w-1:0]   dout,
    output logic                               ok,
    output logic                               sdram_rd,
    output logic [sdram_map_pkg::bank_aw-1:0]  sdram_addr
);
    import sdram_map_pkg::*;

    logic               valid;
    logic               pending;
    logic               hit;
    logic               miss;
    logic               start;
    logic [bank_aw-1:0] addr_q;
    logic [word_w-1:0]  data_q;

    assign hit   = valid && (addr == addr_q);
    assign miss  = cs && !hit;
    // One request at a time, none while the memory is being loaded
    assign start = miss && !pending && !flush;

    // Hit answers in the same cycle as cs
    assign ok         = cs && hit && !flush;
    assign dout       = data_q;
    assign sdram_addr = addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid    <= 1'b0;
            pending  <= 1'b0;
            sdram_rd <= 1'b0;
        end else begin
            if (sdram_ack) begin
                sdram_rd <= 1'b0;
            end
            if (data_rdy) begin
                pending <= 1'b0;
                valid   <= 1'b1;
            end
            if (start) begin
                valid    <= 1'b0;
                pending  <= 1'b1;
                sdram_rd <= 1'b1;
            end
            // Contents are stale once a download starts
            if (flush) begin
                valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= addr;
        end
        if (data_rdy) begin
            data_q <= data_read;
        end
    end

endmodule

// ==== design/sdram_bank_ctrl.sv ====
// Bank controller stand-in with round-robin read arbitration and a fixed latency memory
`timescale 1ns/10ps

module sdram_bank_ctrl (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               downloading,
    input  logic                               prog_we,
    input  logic [sdram_map_pkg::ba_w-1:0]     prog_ba,
    input  logic [sdram_map_pkg::bank_aw-1:0]  prog_addr,
    input  logic [sdram_map_pkg::word_w-1:0]   prog_data,
    input  logic [sdram_map_pkg::bank_count-1:0] sdram_rd,
    input  logic [sdram_map_pkg::bank_count-1:0][sdram_map_pkg::bank_aw-1:0] sdram_addr,
    output logic [sdram_map_pkg::bank_count-1:0] sdram_ack,
    output logic [sdram_map_pkg::bank_count-1:0] data_rdy,
    output logic [sdram_map_pkg::word_w-1:0]   data_read
);
    import sdram_map_pkg::*;

    localparam int mem_words = bank_count * (2 ** bank_aw);

    logic [word_w-1:0] mem [0:mem_words-1];

    logic                             rd_allowed;
    logic                             gnt_vld;
    logic [ba_w-1:0]                  gnt_ba;
    logic [ba_w-1:0]                  last_ba;
    logic [read_lat-1:0]              pipe_vld;
    logic [read_lat-1:0][ba_w-1:0]    pipe_ba;
    logic [read_lat-1:0][word_w-1:0]  pipe_data;

    // Download writes win over reads
    assign rd_allowed = !downloading && !prog_we;

    // Round-robin search starting after the last bank served
    always_comb begin
        logic [ba_w-1:0] cand;
        gnt_vld = 1'b0;
        gnt_ba  = '0;
        for (int k = 1; k <= bank_count; k++) begin
            cand = ba_w'(int'(last_ba) + k);
            if (!gnt_vld && sdram_rd[cand]) begin
                gnt_vld = 1'b1;
                gnt_ba  = cand;
            end
        end
        gnt_vld = gnt_vld && rd_allowed;
    end

    always_comb begin
        sdram_ack = '0;
        if (gnt_vld) begin
            sdram_ack[gnt_ba] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_ba  <= ba_w'(bank_count - 1);
            pipe_vld <= '0;
        end else begin
            if (gnt_vld) begin
                last_ba <= gnt_ba;
            end
            pipe_vld <= {pipe_vld[read_lat-2:0], gnt_vld};
        end
    end

    // Memory array and read pipeline
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[{prog_ba, prog_addr}] <= prog_data;
        end
        pipe_ba[0]   <= gnt_ba;
        pipe_data[0] <= mem[{gnt_ba, sdram_addr[gnt_ba]}];
        for (int s = 1; s < read_lat; s++) begin
            pipe_ba[s]   <= pipe_ba[s-1];
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    // Last stage hands the word back to its bank
    always_comb begin
        data_rdy = '0;
        if (pipe_vld[read_lat-1]) begin
            data_rdy[pipe_ba[read_lat-1]] = 1'b1;
        end
    end

    assign data_read = pipe_data[read_lat-1];

endmodule

// ==== design/game_sdram.sv ====
// Arcade memory map top with ROM download, four client read slots and the bank controller
`timescale 1ns/10ps

module game_sdram (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               lvbl,
    input  logic                               downloading,
    input  logic [sdram_map_pkg::ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]                         ioctl_dout,
    input  logic                               ioctl_wr,
    input  logic                               main_cs,
    input  logic [sdram_map_pkg::cpu_aw-1:0]   main_addr,
    output logic [7:0]                         main_data,
    output logic                               main_ok,
    input  logic                               snd_cs,
    input  logic [sdram_map_pkg::cpu_aw-1:0]   snd_addr,
    output logic [7:0]                         snd_data,
    output logic                               snd_ok,
    input  logic [sdram_map_pkg::bank_aw-1:0]  gfx_addr,
    output logic [sdram_map_pkg::word_w-1:0]   gfx_data,
    output logic                               gfx_ok,
    input  logic                               obj_cs,
    input  logic [sdram_map_pkg::bank_aw-1:0]  obj_addr,
    output logic [sdram_map_pkg::word_w-1:0]   obj_data,
    output logic                               obj_ok,
    output logic [1:0]                         prom_banks,
    output logic                               prom_prior_we,
    output logic                               dwnld_busy
);
    import sdram_map_pkg::*;

    logic                                  prog_we;
    logic [ba_w-1:0]                       prog_ba;
    logic [bank_aw-1:0]                    prog_addr;
    logic [word_w-1:0]                     prog_data;
    logic [bank_count-1:0]                 slot_cs;
    logic [bank_count-1:0][bank_aw-1:0]    slot_addr;
    logic [bank_count-1:0][word_w-1:0]     slot_dout;
    logic [bank_count-1:0]                 slot_ok;
    logic [bank_count-1:0]                 sdram_rd;
    logic [bank_count-1:0][bank_aw-1:0]    sdram_addr;
    logic [bank_count-1:0]                 sdram_ack;
    logic [bank_count-1:0]                 data_rdy;
    logic [word_w-1:0]                     data_read;
    logic                                  dwnld_q;

    // Busy covers the download plus one trailing cycle for the last word write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dwnld_q <= 1'b0;
        end else begin
            dwnld_q <= downloading;
        end
    end

    assign dwnld_busy = downloading || dwnld_q;

    rom_download u_download (
        .clk          (clk),
        .arst_n       (arst_n),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .ioctl_wr     (ioctl_wr),
        .prog_we      (prog_we),
        .prog_ba      (prog_ba),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prom_banks   (prom_banks),
        .prom_prior_we(prom_prior_we)
    );

    client_map u_client_map (
        .main_cs  (main_cs),
        .main_addr(main_addr),
        .snd_cs   (snd_cs),
        .snd_addr (snd_addr),
        .gfx_addr (gfx_addr),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .lvbl     (lvbl),
        .slot_dout(slot_dout),
        .slot_ok  (slot_ok),
        .slot_cs  (slot_cs),
        .slot_addr(slot_addr),
        .main_data(main_data),
        .main_ok  (main_ok),
        .snd_data (snd_data),
        .snd_ok   (snd_ok),
        .gfx_data (gfx_data),
        .gfx_ok   (gfx_ok),
        .obj_data (obj_data),
        .obj_ok   (obj_ok)
    );

    // One slot per bank
    for (genvar i = 0; i < bank_count; i++) begin : g_slot
        rom_slot u_slot (
            .clk       (clk),
            .arst_n    (arst_n),
            .flush     (dwnld_busy),
            .cs        (slot_cs[i]),
            .addr      (slot_addr[i]),
            .sdram_ack (sdram_ack[i]),
            .data_rdy  (data_rdy[i]),
            .data_read (data_read),
            .dout      (slot_dout[i]),
            .ok        (slot_ok[i]),
            .sdram_rd  (sdram_rd[i]),
            .sdram_addr(sdram_addr[i])
        );
    end

    sdram_bank_ctrl u_bank_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .downloading(downloading),
        .prog_we    (prog_we),
        .prog_ba    (prog_ba),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .sdram_rd   (sdram_rd),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .data_read  (data_read)
    );

endmodule

// ==== tests/tb_clock.sv ====
// Clock and reset source for the testbench, 4 ns period with reset held for 4 cycles
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        // Release away from the active edge
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// ==== tests/game_sdram_checker.sv ====
// Bound assertions on the memory map top for slot handshake, read latency and download strobes
`timescale 1ns/10ps

module game_sdram_checker (
    input logic                                clk,
    input logic                                arst_n,
    input logic [sdram_map_pkg::bank_count-1:0] sdram_rd,
    input logic [sdram_map_pkg::bank_count-1:0] sdram_ack,
    input logic [sdram_map_pkg::bank_count-1:0] data_rdy,
    input logic [1:0]                          prom_banks,
    input logic                                prom_prior_we,
    input logic                                dwnld_busy,
    input logic                                main_ok,
    input logic                                snd_ok,
    input logic                                gfx_ok,
    input logic                                obj_ok
);
    import sdram_map_pkg::*;

    for (genvar i = 0; i < bank_count; i++) begin : g_bank
        // Request held until the controller takes it
        a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
            sdram_rd[i] && !sdram_ack[i] |=> sdram_rd[i])
            else $error("bank %0d dropped sdram_rd before ack", i);

        a_rdy_lat: assert property (@(posedge clk) disable iff (!arst_n)
            sdram_ack[i] |-> ##read_lat data_rdy[i])
            else $error("bank %0d data_rdy not %0d cycles after ack", i, read_lat);
    end

    a_prom_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({prom_banks, prom_prior_we}))
        else $error("more than one PROM strobe high");

    // Slots are flushed for the whole download
    a_no_ok_busy: assert property (@(posedge clk) disable iff (!arst_n)
        dwnld_busy |-> !(main_ok || snd_ok || gfx_ok || obj_ok))
        else $error("client ok while download busy");

endmodule

// ==== tests/game_sdram_tb.sv ====
// Testbench for the memory map top, replaying downloads and read checks from the stim file
`timescale 1ns/10ps

module game_sdram_tb;
    import sdram_map_pkg::*;

    localparam int timeout_cycles = 64;

    logic                clk, arst_n;
    logic                lvbl, downloading, ioctl_wr;
    logic [ioctl_aw-1:0] ioctl_addr;
    logic [7:0]          ioctl_dout;
    logic                main_cs, snd_cs, obj_cs;
    logic [cpu_aw-1:0]   main_addr, snd_addr;
    logic [bank_aw-1:0]  gfx_addr, obj_addr;
    logic [7:0]          main_data, snd_data;
    logic [word_w-1:0]   gfx_data, obj_data;
    logic                main_ok, snd_ok, gfx_ok, obj_ok;
    logic [1:0]          prom_banks;
    logic                prom_prior_we, dwnld_busy;

    // Stim records, kind 0 feeds the download queues
    int dl_addr[$];
    int dl_data[$];
    int rd_kind[$];
    int rd_client[$];
    int rd_addr[$];
    int rd_exp[$];

    int checks;
    int value_errs;
    int other_errs;
    int last_single;

    tb_clock u_clock (
        .clk   (clk),
        .arst_n(arst_n)
    );

    game_sdram DUT (.*);

    bind game_sdram game_sdram_checker u_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .sdram_rd     (sdram_rd),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .prom_banks   (prom_banks),
        .prom_prior_we(prom_prior_we),
        .dwnld_busy   (dwnld_busy),
        .main_ok      (main_ok),
        .snd_ok       (snd_ok),
        .gfx_ok       (gfx_ok),
        .obj_ok       (obj_ok)
    );

    // Clients 0 to 3 are main, sound, tiles and objects
    function automatic bit client_ok(input int client);
        case (client)
            0: return main_ok;
            1: return snd_ok;
            2: return gfx_ok;
            default: return obj_ok;
        endcase
    endfunction

    function automatic int client_data(input int client);
        case (client)
            0: return int'(main_data);
            1: return int'(snd_data);
            2: return int'(gfx_data);
            default: return int'(obj_data);
        endcase
    endfunction

    // Strobes as {prior, bank 1, bank 0}, picked by offset bits 9:8
    function automatic int prom_expect(input int addr);
        if (addr < int'(prom_start) || addr >= int'(prom_end)) begin
            return 0;
        end
        case (((addr - int'(prom_start)) >> 8) & 3)
            0: return 1;
            1: return 2;
            2: return 4;
            default: return 0;
        endcase
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            value_errs++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_client(input int client, input bit cs, input int addr);
        case (client)
            0: begin
                main_cs   = cs;
                main_addr = cpu_aw'(addr);
            end
            1: begin
                snd_cs   = cs;
                snd_addr = cpu_aw'(addr);
            end
            2: begin
                lvbl     = cs;
                gfx_addr = bank_aw'(addr);
            end
            default: begin
                obj_cs   = cs;
                obj_addr = bank_aw'(addr);
            end
        endcase
    endtask

    task automatic load_stim();
        int               fd;
        int               n;
        int               lines;
        int               kind, client, addr, value;
        logic [8*128-1:0] skip;
        fd = $fopen("tests/game_sdram_stim.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("stim file tests/game_sdram_stim.txt could not be opened");
            return;
        end
        lines = 0;
        while (!$feof(fd) && lines < 1000) begin
            lines++;
            n = $fscanf(fd, "%h %h %h %h\n", kind, client, addr, value);
            if (n != 4) begin
                // Comment line, drop the rest of it
                n = $fgets(skip, fd);
            end else if (kind == 0) begin
                dl_addr.push_back(addr);
                dl_data.push_back(value);
            end else begin
                rd_kind.push_back(kind);
                rd_client.push_back(client);
                rd_addr.push_back(addr);
                rd_exp.push_back(value);
            end
        end
        $fclose(fd);
        if (dl_addr.size() == 0 || rd_kind.size() == 0) begin
            other_errs++;
            $display("stim file holds no download bytes or no read checks");
        end
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            other_errs++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_ok(input int client, input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!client_ok(client) && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!client_ok(client)) begin
            other_errs++;
            $display("%s gave no ok within %0d cycles", name, timeout_cycles);
        end
    endtask

    task automatic run_download();
        @(negedge clk);
        downloading = 1'b1;
        foreach (dl_addr[i]) begin
            @(negedge clk);
            ioctl_addr = ioctl_aw'(dl_addr[i]);
            ioctl_dout = 8'(dl_data[i]);
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            // PROM pulse is registered one cycle after its byte
            compare_value($sformatf("prom strobes at %0h", dl_addr[i]),
                prom_expect(dl_addr[i]), int'({prom_prior_we, prom_banks}));
            compare_value("busy in download", 1, int'(dwnld_busy));
        end
        @(negedge clk);
        downloading = 1'b0;
        // Trailing busy lasts up to the next rising edge
        #1;
        compare_value("busy trailing cycle", 1, int'(dwnld_busy));
        @(negedge clk);
        compare_value("busy after download", 0, int'(dwnld_busy));
    endtask

    // Reload while a client keeps asking for a word its slot already holds
    task automatic reload_with_request(input int client, input int addr);
        @(negedge clk);
        drive_client(client, 1'b1, addr);
        run_download();
        @(negedge clk);
        drive_client(client, 1'b0, addr);
    endtask

    task automatic single_read(input int client, input int addr, input int expected);
        string name;
        name = $sformatf("read client %0d addr %0h", client, addr);
        @(negedge clk);
        if (client == 2) begin
            // Tile fetch asked outside blanking has to wait
            drive_client(2, 1'b0, addr);
            repeat (6) begin
                @(negedge clk);
                compare_value({name, " gated ok"}, 0, int'(gfx_ok));
            end
            @(negedge clk);
        end
        drive_client(client, 1'b1, addr);
        wait_ok(client, name);
        compare_value(name, expected, client_data(client));
        @(negedge clk);
        drive_client(client, 1'b0, addr);
        // Same address again is served from the slot cache
        @(negedge clk);
        drive_client(client, 1'b1, addr);
        // Ok is due before the next rising edge
        #1;
        compare_value({name, " hit ok"}, 1, int'(client_ok(client)));
        compare_value({name, " hit data"}, expected, client_data(client));
        @(negedge clk);
        drive_client(client, 1'b0, addr);
    endtask

    task automatic group_read();
        int waited;
        bit all_ok;
        @(negedge clk);
        foreach (rd_kind[i]) begin
            if (rd_kind[i] == 2) begin
                drive_client(rd_client[i], 1'b1, rd_addr[i]);
            end
        end
        waited = 0;
        all_ok = 1'b0;
        while (!all_ok && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
            all_ok = 1'b1;
            foreach (rd_kind[i]) begin
                if (rd_kind[i] == 2 && !client_ok(rd_client[i])) begin
                    all_ok = 1'b0;
                end
            end
        end
        if (!all_ok) begin
            other_errs++;
            $display("clients reading together did not all get ok in time");
        end
        foreach (rd_kind[i]) begin
            if (rd_kind[i] == 2) begin
                compare_value($sformatf("group client %0d", rd_client[i]), rd_exp[i],
                    client_data(rd_client[i]));
            end
        end
        @(negedge clk);
        foreach (rd_kind[i]) begin
            if (rd_kind[i] == 2) begin
                drive_client(rd_client[i], 1'b0, rd_addr[i]);
            end
        end
    endtask

    initial begin
        checks      = 0;
        value_errs  = 0;
        other_errs  = 0;
        last_single = -1;
        lvbl        = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        gfx_addr    = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        load_stim();
        wait_reset();
        run_download();
        foreach (rd_kind[i]) begin
            if (rd_kind[i] == 1) begin
                single_read(rd_client[i], rd_addr[i], rd_exp[i]);
                last_single = i;
            end
        end
        // Last single read is still cached in its slot
        if (last_single >= 0) begin
            reload_with_request(rd_client[last_single], rd_addr[last_single]);
        end
        group_read();
        $display("checks %0d, value errors %0d, other errors %0d",
            checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/game_sdram_stim.txt ====
// kind client addr value, all hex; kind 0 download byte, kind 1 single read
// kind 2 reads issued by all clients at once; client 0 main, 1 sound, 2 tiles, 3 objects
0 0 00010 12
0 0 00011 34
0 0 00100 a5
0 0 00101 5a
0 0 02020 9c
0 0 02021 3e
0 0 02200 44
0 0 02201 88
0 0 04040 cd
0 0 04041 ab
0 0 04042 11
0 0 04043 22
0 0 06006 ef
0 0 06007 be
0 0 06100 77
0 0 06101 66
0 0 08005 01
0 0 08105 02
0 0 08205 03
0 0 08305 04
1 0 0010 12
1 0 0011 34
1 1 0020 9c
1 1 0021 3e
1 2 020 abcd
1 3 003 beef
2 0 0100 a5
2 1 0201 88
2 2 021 2211
2 3 080 6677

// ==== compile.f ====
design/sdram_map_pkg.sv
design/rom_download.sv
design/client_map.sv
design/rom_slot.sv
design/sdram_bank_ctrl.sv
design/game_sdram.sv
tests/tb_clock.sv
tests/game_sdram_checker.sv
tests/game_sdram_tb.sv

// ==== Makefile ====
TOP = game_sdram_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
